// File: source/plic_pkg.sv
package plic_pkg;

    localparam int ADDR_W = 26;
    localparam int DATA_W = 32;
    localparam int PRIO_W = 3;

    // byte offsets within the controller window
    localparam logic [ADDR_W-1:0] OFS_PRIO = 26'h000_0000;
    localparam logic [ADDR_W-1:0] OFS_PEND = 26'h000_1000;
    localparam logic [ADDR_W-1:0] OFS_TYPE = 26'h000_1080;
    localparam logic [ADDR_W-1:0] OFS_POL  = 26'h000_1100;
    localparam logic [ADDR_W-1:0] OFS_EN   = 26'h000_2000;
    localparam logic [ADDR_W-1:0] OFS_TH   = 26'h020_0000;

    // per-target spacing of the enable and threshold blocks
    localparam logic [ADDR_W-1:0] EN_STRIDE = 26'h000_0080;
    localparam logic [ADDR_W-1:0] TH_STRIDE = 26'h000_1000;
    // claim/complete word follows the threshold
    localparam logic [ADDR_W-1:0] CLAIM_OFS = 26'h000_0004;

    typedef struct packed {
        logic [PRIO_W-1:0] prio;
        logic              level;
        logic              act_low;
    } src_cfg_t;

    // setup-phase access to one target's claim word
    typedef struct packed {
        logic sel;
        logic wr;
    } claim_acc_t;

endpackage

// File: source/plic_gateway.sv
`timescale 1ns/1ps

module plic_gateway (
    input  logic               clk,
    input  logic               rstn,
    input  logic               src_i,
    input  plic_pkg::src_cfg_t cfg_i,
    input  logic               claim_i,
    input  logic               cmplet_i,
    output logic               pend_o
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_PEND  = 2'b01,
        ST_CLAIM = 2'b10
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   src_act;
    logic   src_lvl_q;
    logic   src_prev_q;
    logic   src_edge_q;
    logic   pol_q;
    logic   set_pend;
    logic   cancel;

    assign src_act = src_i ^ cfg_i.act_low;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            src_lvl_q  <= 1'b0;
            src_prev_q <= 1'b0;
            src_edge_q <= 1'b0;
            pol_q      <= 1'b0;
        end else begin
            src_lvl_q  <= src_act;
            src_prev_q <= src_lvl_q;
            // rising edge of the sampled level
            src_edge_q <= src_lvl_q & ~src_prev_q;
            pol_q      <= cfg_i.act_low;
        end
    end

    assign set_pend = cfg_i.level ? src_lvl_q : src_edge_q;
    // level drop, or any polarity flip
    assign cancel   = (cfg_i.level & ~src_lvl_q) | (cfg_i.act_low ^ pol_q);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:  state_d = set_pend ? ST_PEND : ST_IDLE;
            ST_PEND:  state_d = claim_i ? ST_CLAIM : (cancel ? ST_IDLE : ST_PEND);
            ST_CLAIM: state_d = cmplet_i ? ST_IDLE : ST_CLAIM;
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign pend_o = (state_q == ST_PEND);

endmodule

// File: source/plic_gateway_bank.sv
`timescale 1ns/1ps

module plic_gateway_bank #(
    parameter int N_SRC = 8,
    parameter int N_TGT = 2
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [N_SRC-1:0]               ints_i,
    input  plic_pkg::src_cfg_t [N_SRC-1:0] cfg_i,
    input  logic [N_TGT-1:0][N_SRC-1:0]    claim_i,
    input  logic [N_TGT-1:0][N_SRC-1:0]    cmplet_i,
    output logic [N_SRC-1:0]               pend_o
);

    logic [N_SRC-1:0] claim_any;
    logic [N_SRC-1:0] cmplet_any;

    // any target may claim or complete a given source
    always_comb begin
        claim_any  = '0;
        cmplet_any = '0;
        for (int t = 0; t < N_TGT; t++) begin
            claim_any  = claim_any | claim_i[t];
            cmplet_any = cmplet_any | cmplet_i[t];
        end
    end

    // source 0 is reserved
    assign pend_o[0] = 1'b0;

    for (genvar s = 1; s < N_SRC; s++) begin : g_gw
        plic_gateway u_gateway (
            .clk      (clk),
            .rstn     (rstn),
            .src_i    (ints_i[s]),
            .cfg_i    (cfg_i[s]),
            .claim_i  (claim_any[s]),
            .cmplet_i (cmplet_any[s]),
            .pend_o   (pend_o[s])
        );
    end

endmodule

// File: source/plic_target.sv
`timescale 1ns/1ps

module plic_target #(
    parameter int N_SRC = 8
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic [N_SRC-1:0]               pend_i,
    input  logic [N_SRC-1:0]               en_i,
    input  plic_pkg::src_cfg_t [N_SRC-1:0] cfg_i,
    input  logic [plic_pkg::PRIO_W-1:0]    th_i,
    input  plic_pkg::claim_acc_t           acc_i,
    output logic [$clog2(N_SRC)-1:0]       id_o,
    output logic [N_SRC-1:0]               claim_o,
    output logic [N_SRC-1:0]               cmplet_o,
    output logic                           meip_o
);

    import plic_pkg::*;

    localparam int ID_W   = $clog2(N_SRC);
    localparam int N_LEAF = 1 << ID_W;

    // heap order, node n has children 2n+1 and 2n+2, leaves last
    logic [PRIO_W-1:0] node_prio [2*N_LEAF-1];
    logic [ID_W-1:0]   node_id   [2*N_LEAF-1];
    logic [ID_W-1:0]   id_q;
    logic [ID_W-1:0]   claim_id_q;
    logic [ID_W-1:0]   cmplet_id_q;
    logic              hold;

    for (genvar i = 0; i < N_LEAF; i++) begin : g_leaf
        if (i < N_SRC) begin : g_src
            assign node_prio[N_LEAF-1+i] = (pend_i[i] & en_i[i]) ? cfg_i[i].prio : '0;
        end else begin : g_pad
            assign node_prio[N_LEAF-1+i] = '0;
        end
        assign node_id[N_LEAF-1+i] = ID_W'(i);
    end

    // right child only wins when strictly higher, so ties go to the lower id
    for (genvar n = 0; n < N_LEAF - 1; n++) begin : g_node
        logic take_r;

        assign take_r       = node_prio[2*n+2] > node_prio[2*n+1];
        assign node_prio[n] = take_r ? node_prio[2*n+2] : node_prio[2*n+1];
        assign node_id[n]   = take_r ? node_id[2*n+2] : node_id[2*n+1];
    end

    // non-preemptive: frozen while claimed or while the claim word is accessed
    assign hold = acc_i.sel | (claim_id_q != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            id_q        <= '0;
            claim_id_q  <= '0;
            cmplet_id_q <= '0;
        end else begin
            if (!hold) begin
                id_q <= (node_prio[0] > th_i) ? node_id[0] : '0;
            end
            if (acc_i.sel) begin
                claim_id_q <= acc_i.wr ? '0 : id_q;
            end
            // one-cycle complete carrying the id being released
            cmplet_id_q <= (acc_i.sel & acc_i.wr) ? claim_id_q : '0;
        end
    end

    assign id_o     = id_q;
    assign claim_o  = (claim_id_q != '0) ? (N_SRC'(1) << claim_id_q) : '0;
    assign cmplet_o = (cmplet_id_q != '0) ? (N_SRC'(1) << cmplet_id_q) : '0;
    assign meip_o   = (id_q != claim_id_q);

endmodule

// File: source/plic_regs.sv
`timescale 1ns/1ps

module plic_regs #(
    parameter int N_SRC = 8,
    parameter int N_TGT = 2
) (
    input  logic                                   clk,
    input  logic                                   rstn,
    input  logic                                   psel_i,
    input  logic                                   penable_i,
    input  logic                                   pwrite_i,
    input  logic [plic_pkg::ADDR_W-1:0]            paddr_i,
    input  logic [plic_pkg::DATA_W-1:0]            pwdata_i,
    output logic [plic_pkg::DATA_W-1:0]            prdata_o,
    input  logic [N_SRC-1:0]                       pend_i,
    input  logic [N_TGT-1:0][$clog2(N_SRC)-1:0]    id_i,
    output plic_pkg::src_cfg_t [N_SRC-1:0]         cfg_o,
    output logic [N_TGT-1:0][N_SRC-1:0]            en_o,
    output logic [N_TGT-1:0][plic_pkg::PRIO_W-1:0] th_o,
    output plic_pkg::claim_acc_t [N_TGT-1:0]       acc_o
);

    import plic_pkg::*;

    logic              setup;
    logic              apb_wr;
    logic [PRIO_W-1:0] prio_q [1:N_SRC-1];
    logic [N_SRC-1:0]  type_q;
    logic [N_SRC-1:0]  pol_q;
    logic [N_SRC-1:0]  en_q   [N_TGT];
    logic [PRIO_W-1:0] th_q   [N_TGT];
    logic [DATA_W-1:0] rdata_d;

    function automatic logic [ADDR_W-1:0] prio_addr(input int s);
        return OFS_PRIO + ADDR_W'(4 * s);
    endfunction

    function automatic logic [ADDR_W-1:0] en_addr(input int t);
        return OFS_EN + EN_STRIDE * ADDR_W'(t);
    endfunction

    function automatic logic [ADDR_W-1:0] th_addr(input int t);
        return OFS_TH + TH_STRIDE * ADDR_W'(t);
    endfunction

    assign setup  = psel_i & ~penable_i;
    assign apb_wr = setup & pwrite_i;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 1; s < N_SRC; s++) begin
                prio_q[s] <= '0;
            end
            type_q <= '0;
            pol_q  <= '0;
            for (int t = 0; t < N_TGT; t++) begin
                en_q[t] <= '0;
                th_q[t] <= '0;
            end
        end else if (apb_wr) begin
            // no priority register behind source 0
            for (int s = 1; s < N_SRC; s++) begin
                if (paddr_i == prio_addr(s)) begin
                    prio_q[s] <= pwdata_i[PRIO_W-1:0];
                end
            end
            if (paddr_i == OFS_TYPE) begin
                type_q <= pwdata_i[N_SRC-1:0];
            end
            if (paddr_i == OFS_POL) begin
                pol_q <= pwdata_i[N_SRC-1:0];
            end
            for (int t = 0; t < N_TGT; t++) begin
                if (paddr_i == en_addr(t)) begin
                    en_q[t] <= pwdata_i[N_SRC-1:0];
                end
                if (paddr_i == th_addr(t)) begin
                    th_q[t] <= pwdata_i[PRIO_W-1:0];
                end
            end
        end
    end

    always_comb begin
        cfg_o[0].prio    = '0;
        cfg_o[0].level   = type_q[0];
        cfg_o[0].act_low = pol_q[0];
        for (int s = 1; s < N_SRC; s++) begin
            cfg_o[s].prio    = prio_q[s];
            cfg_o[s].level   = type_q[s];
            cfg_o[s].act_low = pol_q[s];
        end
        for (int t = 0; t < N_TGT; t++) begin
            en_o[t]      = en_q[t];
            th_o[t]      = th_q[t];
            acc_o[t].sel = setup & (paddr_i == th_addr(t) + CLAIM_OFS);
            acc_o[t].wr  = pwrite_i;
        end
    end

    // read mux, one hit at most
    always_comb begin
        rdata_d = '0;
        for (int s = 1; s < N_SRC; s++) begin
            rdata_d = rdata_d | (DATA_W'(prio_q[s]) & {DATA_W{paddr_i == prio_addr(s)}});
        end
        rdata_d = rdata_d | (DATA_W'(pend_i) & {DATA_W{paddr_i == OFS_PEND}});
        rdata_d = rdata_d | (DATA_W'(type_q) & {DATA_W{paddr_i == OFS_TYPE}});
        rdata_d = rdata_d | (DATA_W'(pol_q) & {DATA_W{paddr_i == OFS_POL}});
        for (int t = 0; t < N_TGT; t++) begin
            rdata_d = rdata_d | (DATA_W'(en_q[t]) & {DATA_W{paddr_i == en_addr(t)}});
            rdata_d = rdata_d | (DATA_W'(th_q[t]) & {DATA_W{paddr_i == th_addr(t)}});
            rdata_d = rdata_d |
                      (DATA_W'(id_i[t]) & {DATA_W{paddr_i == th_addr(t) + CLAIM_OFS}});
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_o <= '0;
        end else begin
            prdata_o <= rdata_d;
        end
    end

endmodule

// File: source/plic_top.sv
`timescale 1ns/1ps

module plic_top #(
    parameter int N_SRC = 8,
    parameter int N_TGT = 2
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [plic_pkg::ADDR_W-1:0] paddr_i,
    input  logic [plic_pkg::DATA_W-1:0] pwdata_i,
    output logic [plic_pkg::DATA_W-1:0] prdata_o,
    output logic                        pslverr_o,
    output logic                        pready_o,
    input  logic [N_SRC-1:0]            ints_i,
    output logic [N_TGT-1:0]            meip_o
);

    import plic_pkg::*;

    localparam int ID_W = $clog2(N_SRC);

    src_cfg_t   [N_SRC-1:0]             cfg;
    claim_acc_t [N_TGT-1:0]             acc;
    logic       [N_TGT-1:0][N_SRC-1:0]  en;
    logic       [N_TGT-1:0][PRIO_W-1:0] th;
    logic       [N_TGT-1:0][ID_W-1:0]   id;
    logic       [N_TGT-1:0][N_SRC-1:0]  claim;
    logic       [N_TGT-1:0][N_SRC-1:0]  cmplet;
    logic       [N_SRC-1:0]             pend;

    // every access completes in one cycle
    assign pslverr_o = 1'b0;
    assign pready_o  = 1'b1;

    plic_regs #(
        .N_SRC (N_SRC),
        .N_TGT (N_TGT)
    ) u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pend_i    (pend),
        .id_i      (id),
        .cfg_o     (cfg),
        .en_o      (en),
        .th_o      (th),
        .acc_o     (acc)
    );

    plic_gateway_bank #(
        .N_SRC (N_SRC),
        .N_TGT (N_TGT)
    ) u_gw_bank (
        .clk      (clk),
        .rstn     (rstn),
        .ints_i   (ints_i),
        .cfg_i    (cfg),
        .claim_i  (claim),
        .cmplet_i (cmplet),
        .pend_o   (pend)
    );

    for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
        plic_target #(
            .N_SRC (N_SRC)
        ) u_target (
            .clk      (clk),
            .rstn     (rstn),
            .pend_i   (pend),
            .en_i     (en[t]),
            .cfg_i    (cfg),
            .th_i     (th[t]),
            .acc_i    (acc[t]),
            .id_o     (id[t]),
            .claim_o  (claim[t]),
            .cmplet_o (cmplet[t]),
            .meip_o   (meip_o[t])
        );
    end

endmodule

// File: verif/plic_assert.sv
`timescale 1ns/1ps

module plic_assert #(
    parameter int N_TGT = 2
) (
    input logic                             clk,
    input logic                             rstn,
    input logic                             pready_i,
    input logic [N_TGT-1:0]                 meip_i,
    input plic_pkg::claim_acc_t [N_TGT-1:0] acc_i
);

    pready_high: assert property (@(posedge clk) pready_i)
        else $error("pready dropped low");

    meip_in_reset: assert property (@(posedge clk) !rstn |-> (meip_i == '0))
        else $error("meip high while in reset");

    // a claim read freezes the id, so the request must go away
    for (genvar t = 0; t < N_TGT; t++) begin : g_claim
        meip_after_claim: assert property (@(posedge clk) disable iff (!rstn)
            (acc_i[t].sel && !acc_i[t].wr) |=> !meip_i[t])
            else $error("meip of target %0d still high after a claim read", t);
    end

endmodule

bind plic_top plic_assert #(
    .N_TGT (N_TGT)
) u_plic_assert (
    .clk      (clk),
    .rstn     (rstn),
    .pready_i (pready_o),
    .meip_i   (meip_o),
    .acc_i    (acc)
);

// File: verif/plic_tb.sv
`timescale 1ns/1ps

module plic_tb;

    import plic_pkg::*;

    localparam int N_SRC    = 8;
    localparam int N_TGT    = 2;
    localparam int N_REGCHK = 40;
    localparam int N_ITER   = 40;
    // upper bound on APB transactions over all phases
    localparam int N_TXN    = 2 * N_REGCHK + 10 * N_ITER + 80;

    logic              clk;
    logic              rstn;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [DATA_W-1:0] prdata;
    logic              pslverr;
    logic              pready;
    logic [N_SRC-1:0]  ints;
    logic [N_TGT-1:0]  meip;

    // reference model
    logic [PRIO_W-1:0] mdl_prio [N_SRC];
    logic [N_SRC-1:0]  mdl_en   [N_TGT];
    logic [PRIO_W-1:0] mdl_th   [N_TGT];
    logic [N_SRC-1:0]  mdl_pend;

    int n_checks;
    int n_errors;

    plic_top #(
        .N_SRC (N_SRC),
        .N_TGT (N_TGT)
    ) u_plic_top (
        .clk       (clk),
        .rstn      (rstn),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pslverr_o (pslverr),
        .pready_o  (pready),
        .ints_i    (ints),
        .meip_o    (meip)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (N_TXN * 20) @(posedge clk);
        $display("timeout after %0d cycles, the test sequence did not finish", N_TXN * 20);
        $display(">>> FAIL");
        $finish;
    end

    function automatic logic [ADDR_W-1:0] prio_reg_addr(input int s);
        return OFS_PRIO + ADDR_W'(4 * s);
    endfunction

    function automatic logic [ADDR_W-1:0] en_reg_addr(input int t);
        return OFS_EN + EN_STRIDE * ADDR_W'(t);
    endfunction

    function automatic logic [ADDR_W-1:0] th_reg_addr(input int t);
        return OFS_TH + TH_STRIDE * ADDR_W'(t);
    endfunction

    // highest priority above threshold, lower id kept on ties
    function automatic int expected_id(input int t);
        int                best;
        logic [PRIO_W-1:0] best_prio;
        best      = 0;
        best_prio = mdl_th[t];
        for (int s = 1; s < N_SRC; s++) begin
            if (mdl_pend[s] && mdl_en[t][s] && mdl_prio[s] > best_prio) begin
                best      = s;
                best_prio = mdl_prio[s];
            end
        end
        return best;
    endfunction

    task automatic check_eq(input string what, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("FAILED @%0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        check_eq("pslverr on write", DATA_W'(pslverr), '0);
        check_eq("pready on write", DATA_W'(pready), DATA_W'(1));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // registered at the setup edge
        data    = prdata;
        check_eq("pslverr on read", DATA_W'(pslverr), '0);
        check_eq("pready on read", DATA_W'(pready), DATA_W'(1));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apply_reset();
        rstn = 1'b0;
        ints = '0;
        repeat (2) @(negedge clk);
        rstn     = 1'b1;
        mdl_pend = '0;
        for (int s = 0; s < N_SRC; s++) begin
            mdl_prio[s] = '0;
        end
        for (int t = 0; t < N_TGT; t++) begin
            mdl_en[t] = '0;
            mdl_th[t] = '0;
        end
    endtask

    task automatic pulse_edges(input logic [N_SRC-1:0] mask);
        @(negedge clk);
        ints = mask;
        @(negedge clk);
        ints = '0;
        // source 0 never pends
        mdl_pend = mdl_pend | (mask & ~N_SRC'(1));
    endtask

    task automatic check_pend(input logic [N_SRC-1:0] exp);
        logic [DATA_W-1:0] got;
        read_reg(OFS_PEND, got);
        check_eq("pending word", got, DATA_W'(exp));
    endtask

    task automatic claim_and_check(input int t);
        logic [DATA_W-1:0] got;
        int                exp;
        exp = expected_id(t);
        check_eq($sformatf("meip[%0d]", t), DATA_W'(meip[t]), DATA_W'(exp != 0));
        read_reg(th_reg_addr(t) + CLAIM_OFS, got);
        check_eq($sformatf("claim id of target %0d", t), got, DATA_W'(exp));
        if (exp != 0) begin
            mdl_pend[exp] = 1'b0;
            write_reg(th_reg_addr(t) + CLAIM_OFS, DATA_W'(exp));
            repeat (4) @(negedge clk);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] got;
        logic [DATA_W-1:0] exp;
        logic [ADDR_W-1:0] addr;
        int                s;
        int                t;
        void'($urandom(31));
        n_checks = 0;
        n_errors = 0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        ints     = '0;
        apply_reset();

        // register readback
        write_reg(prio_reg_addr(0), DATA_W'(7));
        read_reg(prio_reg_addr(0), got);
        check_eq("source 0 priority", got, '0);
        for (int i = 0; i < N_REGCHK; i++) begin
            data = $urandom;
            s    = $urandom_range(0, N_SRC - 1);
            t    = $urandom_range(0, N_TGT - 1);
            case ($urandom_range(0, 4))
                0: begin
                    addr = prio_reg_addr(s);
                    exp  = (s == 0) ? '0 : DATA_W'(data[PRIO_W-1:0]);
                end
                1: begin
                    addr = OFS_TYPE;
                    exp  = DATA_W'(data[N_SRC-1:0]);
                end
                2: begin
                    addr = OFS_POL;
                    exp  = DATA_W'(data[N_SRC-1:0]);
                end
                3: begin
                    addr = en_reg_addr(t);
                    exp  = DATA_W'(data[N_SRC-1:0]);
                end
                default: begin
                    addr = th_reg_addr(t);
                    exp  = DATA_W'(data[PRIO_W-1:0]);
                end
            endcase
            write_reg(addr, data);
            read_reg(addr, got);
            check_eq($sformatf("readback at %0h", addr), got, exp);
        end

        // random edges against the model
        apply_reset();
        for (int i = 0; i < N_ITER; i++) begin
            s           = $urandom_range(1, N_SRC - 1);
            mdl_prio[s] = PRIO_W'($urandom);
            write_reg(prio_reg_addr(s), DATA_W'(mdl_prio[s]));
            for (t = 0; t < N_TGT; t++) begin
                mdl_en[t] = N_SRC'($urandom);
                mdl_th[t] = PRIO_W'($urandom_range(0, 3));
                write_reg(en_reg_addr(t), DATA_W'(mdl_en[t]));
                write_reg(th_reg_addr(t), DATA_W'(mdl_th[t]));
            end
            pulse_edges(N_SRC'($urandom));
            repeat (5) @(negedge clk);
            check_pend(mdl_pend);
            for (t = 0; t < N_TGT; t++) begin
                claim_and_check(t);
            end
        end

        // top threshold masks every source
        for (t = 0; t < N_TGT; t++) begin
            mdl_th[t] = '1;
            write_reg(th_reg_addr(t), DATA_W'(mdl_th[t]));
        end
        for (int i = 0; i < 8; i++) begin
            pulse_edges(N_SRC'($urandom));
            repeat (5) @(negedge clk);
            for (t = 0; t < N_TGT; t++) begin
                claim_and_check(t);
            end
        end

        // level source, claim, complete, re-pend, then drop
        apply_reset();
        s = $urandom_range(1, N_SRC - 1);
        write_reg(prio_reg_addr(s), DATA_W'($urandom_range(1, 7)));
        write_reg(OFS_TYPE, DATA_W'(1) << s);
        write_reg(en_reg_addr(0), DATA_W'(1) << s);
        ints[s] = 1'b1;
        repeat (4) @(negedge clk);
        check_pend(N_SRC'(1) << s);
        check_eq("meip[0] level", DATA_W'(meip[0]), DATA_W'(1));
        read_reg(th_reg_addr(0) + CLAIM_OFS, got);
        check_eq("level claim id", got, DATA_W'(s));
        repeat (2) @(negedge clk);
        check_pend('0);
        write_reg(th_reg_addr(0) + CLAIM_OFS, DATA_W'(s));
        repeat (4) @(negedge clk);
        check_pend(N_SRC'(1) << s);
        check_eq("meip[0] re-pend", DATA_W'(meip[0]), DATA_W'(1));
        ints[s] = 1'b0;
        repeat (4) @(negedge clk);
        check_pend('0);
        check_eq("meip[0] dropped", DATA_W'(meip[0]), '0);

        // active-low level source
        apply_reset();
        s = $urandom_range(1, N_SRC - 1);
        write_reg(prio_reg_addr(s), DATA_W'($urandom_range(1, 7)));
        write_reg(OFS_TYPE, DATA_W'(1) << s);
        write_reg(en_reg_addr(0), DATA_W'(1) << s);
        write_reg(OFS_POL, DATA_W'(1) << s);
        repeat (4) @(negedge clk);
        check_pend(N_SRC'(1) << s);
        check_eq("meip[0] active low", DATA_W'(meip[0]), DATA_W'(1));
        ints[s] = 1'b1;
        repeat (4) @(negedge clk);
        check_pend('0);
        check_eq("meip[0] inactive high", DATA_W'(meip[0]), '0);

        // enabled on target 1 only
        apply_reset();
        s           = $urandom_range(1, N_SRC - 1);
        mdl_prio[s] = PRIO_W'($urandom_range(1, 7));
        mdl_en[1]   = N_SRC'(1) << s;
        write_reg(prio_reg_addr(s), DATA_W'(mdl_prio[s]));
        write_reg(en_reg_addr(1), DATA_W'(mdl_en[1]));
        pulse_edges(N_SRC'(1) << s);
        repeat (5) @(negedge clk);
        claim_and_check(0);
        claim_and_check(1);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: plic.f
source/plic_pkg.sv
source/plic_gateway.sv
source/plic_gateway_bank.sv
source/plic_target.sv
source/plic_regs.sv
source/plic_top.sv
verif/plic_assert.sv
verif/plic_tb.sv

// File: Bender.yml
package:
  name: plic

sources:
  - source/plic_pkg.sv
  - source/plic_gateway.sv
  - source/plic_gateway_bank.sv
  - source/plic_target.sv
  - source/plic_regs.sv
  - source/plic_top.sv
  - target: simulation
    files:
      - verif/plic_assert.sv
      - verif/plic_tb.sv
